// File: sim.f
+incdir+test
verilog/bus_pkg.sv
verilog/soc_pkg.sv
verilog/pi_bus_if.sv
verilog/bus_decoder.sv
verilog/dev_table.sv
verilog/gpio_port.sv
verilog/reset_seq.sv
verilog/soc_top.sv
test/tb_soc_top.sv

// File: test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// prints the reason and ends the run
task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("RESULT: FAIL");
	$fatal(1);
endtask

task automatic check_data(input string name, input pi_data_t got, input pi_data_t exp);
	if (got !== exp) begin
		abort_run($sformatf("error: %s got 0x%08h expected 0x%08h", name, got, exp));
	end
endtask

task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
	if (got !== exp) begin
		abort_run($sformatf("error: %s got 0x%02h expected 0x%02h", name, got, exp));
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
	end
endtask

task automatic check_cycles(input string name, input int got, input int exp);
	if (got != exp) begin
		abort_run($sformatf("error: %s cycles got 0x%0h expected 0x%0h", name, got, exp));
	end
endtask

// request held from one falling edge until ready is seen on a later one
task automatic bus_access(input pi_op_e op, input pi_addr_t addr, input pi_data_t wdata,
	input pi_sel_t sel, input int exp_cycles, output pi_data_t rdata);
	int cycles;
	@(negedge clk);
	pi_op    = op;
	pi_addr  = addr;
	pi_wdata = wdata;
	pi_sel   = sel;
	cycles   = 0;
	do begin
		@(negedge clk);
		cycles++;
		if (cycles > ACCESS_LIMIT) begin
			abort_run("bus access never got a ready from the DUT");
		end
	end while (pi_rdy !== 1'b1);
	rdata = pi_rdata;
	pi_op = OP_NOP;
	check_cycles("pi_rdy_o", cycles, exp_cycles);
endtask

task automatic bus_write(input pi_addr_t addr, input pi_data_t wdata, input pi_sel_t sel,
	input int exp_cycles);
	pi_data_t unused;
	bus_access(OP_WR, addr, wdata, sel, exp_cycles, unused);
endtask

task automatic bus_read(input pi_addr_t addr, input int exp_cycles, output pi_data_t rdata);
	bus_access(OP_RD, addr, '0, '1, exp_cycles, rdata);
endtask

// counts falling edges until the peripheral reset drops
task automatic check_reset_release();
	int cycles;
	cycles = 0;
	while (periph_rst === 1'b1) begin
		@(negedge clk);
		cycles++;
		if (cycles > RELEASE_LIMIT) begin
			abort_run("peripheral reset did not release after the countdown");
		end
	end
	check_cycles("periph_rst_o", cycles, RST_HOLD_CYCLES);
endtask

task automatic apply_reset();
	@(negedge clk);
	rst_p = 1'b1;
	repeat (RST_ASSERT_CYCLES) @(negedge clk);
	check_bit("periph_rst_o", periph_rst, 1'b1);
	rst_p = 1'b0;
	check_reset_release();
endtask

task automatic test_device_table();
	pi_data_t rdata;
	pi_data_t expect_words [2*SLOT_COUNT];
	foreach (expect_words[i]) begin
		expect_words[i] = '0;
	end
	expect_words[2*SLOT_DEVTBL]   = pi_data_t'(DEV_ID_DEVTBL);
	expect_words[2*SLOT_DEVTBL+1] = pi_data_t'(MAPSZ_DEVTBL);
	expect_words[2*SLOT_GPIO]     = pi_data_t'(DEV_ID_GPIO);
	expect_words[2*SLOT_GPIO+1]   = pi_data_t'(MAPSZ_GPIO);
	for (int w = 0; w < 2*SLOT_COUNT; w++) begin
		bus_read(pi_addr_t'(w), DEV_CYCLES, rdata);
		check_data("pi_rdata_o", rdata, expect_words[w]);
	end
	// just past the table, where a wrapped index would land on slot 0
	bus_read(pi_addr_t'(2*SLOT_COUNT + 1), DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
	bus_read(CTRL_ADDR, DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
endtask

task automatic test_gpio();
	pi_data_t rdata;
	gpio_t    sample;
	bus_write(GPIO_BASE, 32'h0000_00a5, 4'b0001, DEV_CYCLES);
	check_gpio("gp_o", gp_out, 8'ha5);
	// lane 0 not selected
	bus_write(GPIO_BASE, 32'h1234_565a, 4'b1110, DEV_CYCLES);
	check_gpio("gp_o", gp_out, 8'ha5);
	bus_write(GPIO_BASE, 32'hffff_ff3c, 4'b0011, DEV_CYCLES);
	check_gpio("gp_o", gp_out, 8'h3c);
	bus_read(GPIO_BASE, DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, 32'h0000_003c);
	// swap returns the old output value
	bus_access(OP_RW, GPIO_BASE, 32'h0000_00c3, 4'b0001, DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, 32'h0000_003c);
	check_gpio("gp_o", gp_out, 8'hc3);
	repeat (GP_SAMPLES) begin
		sample = gpio_t'($urandom);
		@(negedge clk);
		gp_in = sample;
		repeat (SYNC_WAIT) @(negedge clk);
		bus_read(pi_addr_t'(GPIO_BASE + 1), DEV_CYCLES, rdata);
		check_data("pi_rdata_o", rdata, pi_data_t'(sample));
	end
endtask

task automatic test_default_slave();
	pi_data_t rdata;
	gpio_t    held;
	held = gp_out;
	bus_read(pi_addr_t'(SLOT_NONE_A * SLOT_WORDS + 3), DFLT_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
	bus_read(pi_addr_t'(SLOT_NONE_B * SLOT_WORDS + 1023), DFLT_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
	bus_read(HIGH_BASE | GPIO_BASE, DFLT_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
	bus_write(pi_addr_t'(SLOT_NONE_A * SLOT_WORDS), 32'hffff_ffff, 4'hf, DFLT_CYCLES);
	// aliases of the control word and the output register above the slots
	bus_write(HIGH_BASE | CTRL_ADDR, 32'h0000_0002, 4'hf, DFLT_CYCLES);
	bus_write(HIGH_BASE | GPIO_BASE, 32'h0000_00ff, 4'hf, DFLT_CYCLES);
	check_gpio("gp_o", gp_out, held);
	check_bit("periph_rst_o", periph_rst, 1'b0);
	bus_read(CTRL_ADDR, DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
endtask

task automatic test_soft_reset(input logic [1:0] kind);
	pi_data_t rdata;
	bus_write(GPIO_BASE, 32'h0000_005a, 4'b0001, DEV_CYCLES);
	check_gpio("gp_o", gp_out, 8'h5a);
	bus_write(CTRL_ADDR, pi_data_t'(kind), 4'b0001, DEV_CYCLES);
	check_bit("periph_rst_o", periph_rst, 1'b1);
	check_reset_release();
	check_gpio("gp_o", gp_out, '0);
	bus_read(CTRL_ADDR, DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, pi_data_t'(kind));
endtask

task automatic test_power_off();
	pi_data_t rdata;
	bus_write(GPIO_BASE, 32'h0000_0077, 4'b0001, DEV_CYCLES);
	check_gpio("gp_o", gp_out, 8'h77);
	bus_write(CTRL_ADDR, 32'h0000_0001, 4'b0001, DEV_CYCLES);
	// held long past the countdown length
	repeat (OFF_HOLD_CYCLES) begin
		check_bit("periph_rst_o", periph_rst, 1'b1);
		@(negedge clk);
	end
	check_gpio("gp_o", gp_out, '0);
	apply_reset();
	bus_read(CTRL_ADDR, DEV_CYCLES, rdata);
	check_data("pi_rdata_o", rdata, '0);
	check_gpio("gp_o", gp_out, '0);
endtask

`endif

// File: test/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;
	import bus_pkg::*;
	import soc_pkg::*;

	localparam int SEED              = 28724;
	localparam int CLK_HALF_NS       = 5;
	localparam int RST_ASSERT_CYCLES = 4;
	localparam int DEV_CYCLES        = 3;
	localparam int DFLT_CYCLES       = 2;
	localparam int ACCESS_LIMIT      = 32;
	localparam int RELEASE_LIMIT     = RST_HOLD_CYCLES + 8;
	localparam int GP_SAMPLES        = 4;
	localparam int SYNC_WAIT         = 4;
	localparam int OFF_HOLD_CYCLES   = 40;

	// watchdog budget summed over the test sequence
	localparam int ACCESS_COUNT   = 48;
	localparam int ACCESS_SLOT    = DEV_CYCLES + 2;
	localparam int RESET_RUNS     = 4;
	localparam int RESET_SLOT     = RST_ASSERT_CYCLES + RST_HOLD_CYCLES + 2;
	localparam int MARGIN_CYCLES  = 200;
	localparam int TIMEOUT_CYCLES = ACCESS_COUNT * ACCESS_SLOT + RESET_RUNS * RESET_SLOT +
		GP_SAMPLES * (SYNC_WAIT + 1) + OFF_HOLD_CYCLES + MARGIN_CYCLES;

	// word addresses as seen on the top-level bus
	localparam pi_addr_t CTRL_ADDR = pi_addr_t'(SLOT_DEVTBL * SLOT_WORDS + DEVTBL_CTRL_WORD);
	localparam pi_addr_t GPIO_BASE = pi_addr_t'(SLOT_GPIO * SLOT_WORDS);
	localparam pi_addr_t HIGH_BASE = pi_addr_t'(SLOT_COUNT * SLOT_WORDS);

	logic     clk;
	logic     rst_p;
	pi_op_e   pi_op;
	pi_addr_t pi_addr;
	pi_data_t pi_wdata;
	pi_sel_t  pi_sel;
	gpio_t    gp_in;
	pi_data_t pi_rdata;
	logic     pi_rdy;
	gpio_t    gp_out;
	logic     periph_rst;

	soc_top DUT (
		 .clk100mhz_i  (clk)
		,.rst_p        (rst_p)
		,.pi_op_i      (pi_op)
		,.pi_addr_i    (pi_addr)
		,.pi_wdata_i   (pi_wdata)
		,.pi_sel_i     (pi_sel)
		,.gp_i         (gp_in)
		,.pi_rdata_o   (pi_rdata)
		,.pi_rdy_o     (pi_rdy)
		,.gp_o         (gp_out)
		,.periph_rst_o (periph_rst)
	);

	`include "tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #CLK_HALF_NS clk = ~clk;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the test sequence finished");
	end

	initial begin
		void'($urandom(SEED));
		rst_p    = 1'b1;
		pi_op    = OP_NOP;
		pi_addr  = '0;
		pi_wdata = '0;
		pi_sel   = '0;
		gp_in    = '0;

		apply_reset();
		test_device_table();
		test_gpio();
		test_default_slave();
		// warm then cold
		test_soft_reset(2'd2);
		test_soft_reset(2'd3);
		test_power_off();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	 input  wire               clk100mhz_i
	,input  wire               periph_rst_i
	,input  wire bus_pkg::pi_op_e   pi_op_i
	,input  wire bus_pkg::pi_addr_t pi_addr_i
	,input  wire bus_pkg::pi_data_t pi_wdata_i
	,input  wire bus_pkg::pi_sel_t  pi_sel_i
	,output bus_pkg::pi_data_t pi_rdata_o
	,output logic              pi_rdy_o
	,pi_bus_if.master          devtbl_bus
	,pi_bus_if.master          gpio_bus
);
	import bus_pkg::*;
	import soc_pkg::*;

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT, RESPOND} state_e;

	state_e   state_q;
	pi_op_e   op_q;
	pi_addr_t offs_q;
	pi_data_t wdata_q;
	pi_sel_t  sel_q;
	slot_t    slot_q;
	logic     dflt_q;
	pi_data_t rdata_q;

	slot_t    req_slot;
	logic     slot_empty;
	logic     req_dflt;
	logic     bus_active;
	logic     slave_rdy;
	pi_data_t slave_rdata;

	assign req_slot = pi_addr_i[SLOT_OFFS_BITS +: SLOT_BITS];

	always_comb begin
		case (req_slot)
			SLOT_NONE_A, SLOT_NONE_B: slot_empty = 1'b1;
			default: slot_empty = 1'b0;
		endcase
	end

	// anything above the four slots lands on the default slave
	assign req_dflt = slot_empty || (|pi_addr_i[ADDR_BITS-1:SLOT_OFFS_BITS+SLOT_BITS]);

	always_ff @(posedge clk100mhz_i) begin
		if (periph_rst_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (pi_op_i != OP_NOP) begin
						state_q <= ISSUE;
					end
				end
				ISSUE: begin
					state_q <= dflt_q ? RESPOND : WAIT;
				end
				WAIT: begin
					if (slave_rdy) begin
						state_q <= RESPOND;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// request is sampled while idle and held for the whole access
	always_ff @(posedge clk100mhz_i) begin
		if (state_q == IDLE) begin
			op_q    <= pi_op_i;
			offs_q  <= pi_addr_t'(pi_addr_i[SLOT_OFFS_BITS-1:0]);
			wdata_q <= pi_wdata_i;
			sel_q   <= pi_sel_i;
			slot_q  <= req_slot;
			dflt_q  <= req_dflt;
		end
		if (state_q == ISSUE && dflt_q) begin
			rdata_q <= '0;
		end else if (state_q == WAIT && slave_rdy) begin
			rdata_q <= slave_rdata;
		end
	end

	// only the selected slave ever sees a live op
	assign bus_active = (state_q == ISSUE || state_q == WAIT) && !dflt_q;

	assign devtbl_bus.op    = (bus_active && slot_q == SLOT_DEVTBL) ? op_q : OP_NOP;
	assign devtbl_bus.addr  = offs_q;
	assign devtbl_bus.wdata = wdata_q;
	assign devtbl_bus.sel   = sel_q;

	assign gpio_bus.op    = (bus_active && slot_q == SLOT_GPIO) ? op_q : OP_NOP;
	assign gpio_bus.addr  = offs_q;
	assign gpio_bus.wdata = wdata_q;
	assign gpio_bus.sel   = sel_q;

	assign slave_rdy   = (slot_q == SLOT_GPIO) ? gpio_bus.rdy : devtbl_bus.rdy;
	assign slave_rdata = (slot_q == SLOT_GPIO) ? gpio_bus.rdata : devtbl_bus.rdata;

	assign pi_rdy_o   = (state_q == RESPOND);
	assign pi_rdata_o = rdata_q;

	a_rdy_single: assert property (@(posedge clk100mhz_i) pi_rdy_o |=> !pi_rdy_o);

endmodule

`default_nettype wire

// File: verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// data path and word addressing of the peripheral bus
	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = 30;
	localparam int SEL_BITS  = ARCH_BITS / 8;

	typedef logic [ARCH_BITS-1:0] pi_data_t;
	typedef logic [ADDR_BITS-1:0] pi_addr_t;
	typedef logic [SEL_BITS-1:0]  pi_sel_t;

	// op code is held by the master until the one-cycle ready
	// OP_RW returns the old word and writes the new one
	typedef enum logic [1:0] {
		 OP_NOP = 2'b00
		,OP_WR  = 2'b01
		,OP_RD  = 2'b10
		,OP_RW  = 2'b11
	} pi_op_e;

endpackage

`default_nettype wire

// File: verilog/dev_table.sv
`timescale 1ns/1ps
`default_nettype none

module dev_table (
	 input  wire              clk100mhz_i
	,input  wire              rst_p
	,pi_bus_if.slave          bus
	,output soc_pkg::rst_req_e rst_req_o
);
	import bus_pkg::*;
	import soc_pkg::*;

	logic [1:0] ctrl_q;
	logic       rdy_q;
	pi_data_t   rdata_q;
	logic       access;
	logic       ctrl_hit;
	logic       ctrl_wr;
	pi_data_t   table_word;

	function automatic pi_data_t slot_id(input slot_t slot);
		case (slot)
			SLOT_DEVTBL: return pi_data_t'(DEV_ID_DEVTBL);
			SLOT_GPIO: return pi_data_t'(DEV_ID_GPIO);
			default: return '0;
		endcase
	endfunction

	function automatic pi_data_t slot_mapsz(input slot_t slot);
		case (slot)
			SLOT_DEVTBL: return pi_data_t'(MAPSZ_DEVTBL);
			SLOT_GPIO: return pi_data_t'(MAPSZ_GPIO);
			default: return '0;
		endcase
	endfunction

	// the op stays up during the ready cycle so it only counts once
	assign access   = (bus.op != OP_NOP) && !rdy_q;
	assign ctrl_hit = (bus.addr == pi_addr_t'(DEVTBL_CTRL_WORD));
	assign ctrl_wr  = access && ctrl_hit && bus.sel[0] &&
		(bus.op == OP_WR || bus.op == OP_RW);

	// even word is the slot id, odd word its map size
	always_comb begin
		table_word = '0;
		if (ctrl_hit) begin
			table_word = pi_data_t'(ctrl_q);
		end else if (bus.addr < pi_addr_t'(2 * SLOT_COUNT)) begin
			if (bus.addr[0]) begin
				table_word = slot_mapsz(bus.addr[SLOT_BITS:1]);
			end else begin
				table_word = slot_id(bus.addr[SLOT_BITS:1]);
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			rdy_q     <= 1'b0;
			ctrl_q    <= '0;
			rst_req_o <= REQ_NONE;
		end else begin
			rdy_q     <= access;
			rst_req_o <= REQ_NONE;
			if (ctrl_wr) begin
				ctrl_q    <= bus.wdata[1:0];
				rst_req_o <= rst_req_e'(bus.wdata[1:0]);
			end
		end
	end

	// read data is taken before the write so OP_RW sees the old value
	always_ff @(posedge clk100mhz_i) begin
		if (access) begin
			rdata_q <= table_word;
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;

	a_req_pulse: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		(rst_req_o != REQ_NONE) |=> (rst_req_o == REQ_NONE));

endmodule

`default_nettype wire

// File: verilog/gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	 input  wire                 clk100mhz_i
	,input  wire                 periph_rst_i
	,input  wire soc_pkg::gpio_t gp_i
	,pi_bus_if.slave             bus
	,output soc_pkg::gpio_t      gp_o
);
	import bus_pkg::*;
	import soc_pkg::*;

	gpio_t    out_q;
	gpio_t    sync0_q;
	gpio_t    sync1_q;
	logic     rdy_q;
	pi_data_t rdata_q;
	logic     access;
	logic     out_wr;
	pi_data_t rd_word;

	// pins are asynchronous to the bus clock
	always_ff @(posedge clk100mhz_i) begin
		sync0_q <= gp_i;
		sync1_q <= sync0_q;
	end

	assign access = (bus.op != OP_NOP) && !rdy_q;
	assign out_wr = access && (bus.addr == '0) && bus.sel[0] &&
		(bus.op == OP_WR || bus.op == OP_RW);

	// word 0 output register, word 1 synchronised inputs
	always_comb begin
		case (bus.addr)
			pi_addr_t'(0): rd_word = pi_data_t'(out_q);
			pi_addr_t'(1): rd_word = pi_data_t'(sync1_q);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk100mhz_i) begin
		if (periph_rst_i) begin
			rdy_q <= 1'b0;
			out_q <= '0;
		end else begin
			rdy_q <= access;
			if (out_wr) begin
				out_q <= bus.wdata[GPIO_COUNT-1:0];
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (access) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdy   = rdy_q;
	assign bus.rdata = rdata_q;
	assign gp_o      = out_q;

endmodule

`default_nettype wire

// File: verilog/pi_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pi_bus_if;
	import bus_pkg::*;

	pi_op_e   op;
	// word offset inside the slot
	pi_addr_t addr;
	pi_data_t wdata;
	pi_sel_t  sel;
	pi_data_t rdata;
	logic     rdy;

	modport master (
		 output op
		,output addr
		,output wdata
		,output sel
		,input  rdata
		,input  rdy
	);

	modport slave (
		 input  op
		,input  addr
		,input  wdata
		,input  sel
		,output rdata
		,output rdy
	);

endinterface

`default_nettype wire

// File: verilog/reset_seq.sv
`timescale 1ns/1ps
`default_nettype none

module reset_seq (
	 input  wire                    clk100mhz_i
	,input  wire                    rst_p
	,input  wire soc_pkg::rst_req_e rst_req_i
	,output logic                   periph_rst_o
);
	import soc_pkg::*;

	rst_cnt_t cnt_q;
	logic     off_q;
	logic     reload;

	// cold and warm requests both restart the countdown
	assign reload = rst_p || (rst_req_i == REQ_WARM) || (rst_req_i == REQ_COLD);

	always_ff @(posedge clk100mhz_i) begin
		if (reload) begin
			cnt_q <= rst_cnt_t'(RST_HOLD_CYCLES);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// power-off holds the peripherals until the next board reset
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			off_q <= 1'b0;
		end else if (rst_req_i == REQ_POWEROFF) begin
			off_q <= 1'b1;
		end
	end

	assign periph_rst_o = rst_p || (cnt_q != '0) || off_q;

	a_off_holds: assert property (@(posedge clk100mhz_i)
		(off_q && !rst_p) |=> periph_rst_o);

endmodule

`default_nettype wire

// File: verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// four fixed 4 KB slots, picked by word address bits 11:10
	localparam int SLOT_COUNT     = 4;
	localparam int SLOT_WORDS     = 1024;
	localparam int SLOT_BITS      = $clog2(SLOT_COUNT);
	localparam int SLOT_OFFS_BITS = $clog2(SLOT_WORDS);

	typedef logic [SLOT_BITS-1:0] slot_t;

	localparam slot_t SLOT_DEVTBL = 2'd0;
	localparam slot_t SLOT_GPIO   = 2'd1;
	localparam slot_t SLOT_NONE_A = 2'd2;
	localparam slot_t SLOT_NONE_B = 2'd3;

	// ids and map sizes listed in the device table
	localparam int DEV_ID_DEVTBL = 7;
	localparam int DEV_ID_GPIO   = 6;
	localparam int MAPSZ_DEVTBL  = SLOT_WORDS;
	localparam int MAPSZ_GPIO    = 2;

	// last word of the device table slot
	localparam int DEVTBL_CTRL_WORD = 1023;

	localparam int GPIO_COUNT = 8;
	typedef logic [GPIO_COUNT-1:0] gpio_t;

	localparam int RST_HOLD_CYCLES = 16;
	typedef logic [4:0] rst_cnt_t;

	// encoding matches bits 1:0 written to the control word
	typedef enum logic [1:0] {
		 REQ_NONE     = 2'd0
		,REQ_POWEROFF = 2'd1
		,REQ_WARM     = 2'd2
		,REQ_COLD     = 2'd3
	} rst_req_e;

endpackage

`default_nettype wire

// File: verilog/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	 input  wire                    clk100mhz_i
	,input  wire                    rst_p
	,input  wire bus_pkg::pi_op_e   pi_op_i
	,input  wire bus_pkg::pi_addr_t pi_addr_i
	,input  wire bus_pkg::pi_data_t pi_wdata_i
	,input  wire bus_pkg::pi_sel_t  pi_sel_i
	,input  wire soc_pkg::gpio_t    gp_i
	,output bus_pkg::pi_data_t      pi_rdata_o
	,output logic                   pi_rdy_o
	,output soc_pkg::gpio_t         gp_o
	,output logic                   periph_rst_o
);
	import soc_pkg::*;

	rst_req_e rst_req;
	logic     periph_rst;

	pi_bus_if devtbl_bus ();
	pi_bus_if gpio_bus ();

	bus_decoder decoder (
		 .clk100mhz_i  (clk100mhz_i)
		,.periph_rst_i (periph_rst)
		,.pi_op_i      (pi_op_i)
		,.pi_addr_i    (pi_addr_i)
		,.pi_wdata_i   (pi_wdata_i)
		,.pi_sel_i     (pi_sel_i)
		,.pi_rdata_o   (pi_rdata_o)
		,.pi_rdy_o     (pi_rdy_o)
		,.devtbl_bus   (devtbl_bus.master)
		,.gpio_bus     (gpio_bus.master)
	);

	// stays on the board reset so it can issue the next request
	dev_table devtbl (
		 .clk100mhz_i (clk100mhz_i)
		,.rst_p       (rst_p)
		,.bus         (devtbl_bus.slave)
		,.rst_req_o   (rst_req)
	);

	gpio_port gpio (
		 .clk100mhz_i  (clk100mhz_i)
		,.periph_rst_i (periph_rst)
		,.gp_i         (gp_i)
		,.bus          (gpio_bus.slave)
		,.gp_o         (gp_o)
	);

	reset_seq rstseq (
		 .clk100mhz_i  (clk100mhz_i)
		,.rst_p        (rst_p)
		,.rst_req_i    (rst_req)
		,.periph_rst_o (periph_rst)
	);

	assign periph_rst_o = periph_rst;

endmodule

`default_nettype wire
